// ==== hw/drw_cfg.svh ====
// Register map, opcodes, error numbers and sizing constants of the drawing engine
`ifndef DRW_CFG_SVH
`define DRW_CFG_SVH

// Register byte offsets
`define DRW_REG_CTRL      16'h0000
`define DRW_REG_STATUS    16'h0004
`define DRW_REG_INT       16'h0008
`define DRW_REG_ERRNO     16'h000C
`define DRW_REG_FIFO      16'h0010

`define DRW_FIFO_DEPTH    2048
`define DRW_MAX_BURST     256

// Top address bits, keeps writes inside 0x2000_0000..0x3FFF_FFFF
`define DRW_VRAM_BASE     3'b001

`define DRW_OP_SETFRAME   8'h01
`define DRW_OP_SETCOLOR   8'h02
`define DRW_OP_FILLRECT   8'h03
`define DRW_OP_END        8'h0F

`define DRW_ERR_OPCODE    16'd1
`define DRW_ERR_RANGE     16'd2
`define DRW_ERR_WIDTH     16'd3

`endif

// ==== hw/drw_pkg.sv ====
// Command word union, opcode and error number types
package drw_pkg;

`include "drw_cfg.svh"

    typedef enum logic [7:0] {
        OP_SETFRAME = `DRW_OP_SETFRAME,
        OP_SETCOLOR = `DRW_OP_SETCOLOR,
        OP_FILLRECT = `DRW_OP_FILLRECT,
        OP_END      = `DRW_OP_END
    } drw_opcode_e;

    typedef enum logic [15:0] {
        ERR_NONE   = 16'd0,
        ERR_OPCODE = `DRW_ERR_OPCODE,
        ERR_RANGE  = `DRW_ERR_RANGE,
        ERR_WIDTH  = `DRW_ERR_WIDTH
    } drw_errno_e;

    // One FIFO word, seen as header or as x/y pair
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0]  opcode;
            logic [23:0] arg;
        } hdr;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } pair;
    } drw_cmd_word_u;

endpackage

// ==== hw/drw_regctrl.sv ====
// Register bus decode, control and status registers, interrupt logic, FIFO write port
`timescale 1ns/10ps
`include "drw_cfg.svh"

module drw_regctrl import drw_pkg::*; (
    input  logic          ACLK,
    input  logic          rst,
    input  logic [15:0]   wraddr,
    input  logic          wren,
    input  logic [31:0]   wdata,
    input  logic [15:0]   rdaddr,
    input  logic          rden,
    output logic [31:0]   rdata,
    output logic          fifo_wr,
    output drw_cmd_word_u fifo_din,
    input  logic          fifo_full,
    input  logic [11:0]   fifo_count,
    output logic          exe,
    output logic          soft_rst,
    output logic          irq,
    input  logic          busy,
    input  logic          finish,
    input  drw_errno_e    errno
);

    logic ctrl_wr;
    logic int_wr;
    logic int_en;
    logic int_pend;
    logic overflow;
    logic finish_d;

    assign ctrl_wr      = wren && (wraddr == `DRW_REG_CTRL);
    assign int_wr       = wren && (wraddr == `DRW_REG_INT);
    assign fifo_wr      = wren && (wraddr == `DRW_REG_FIFO);
    assign fifo_din.raw = wdata;
    assign irq          = int_pend && int_en;

    // Write-one pulses, never read back
    always_ff @(posedge ACLK) begin
        if (rst) begin
            exe      <= 1'b0;
            soft_rst <= 1'b0;
        end else begin
            exe      <= ctrl_wr && wdata[0];
            soft_rst <= ctrl_wr && wdata[1];
        end
    end

    always_ff @(posedge ACLK) begin
        if (rst) begin
            int_en <= 1'b0;
        end else if (int_wr) begin
            int_en <= wdata[0];
        end
    end

    always_ff @(posedge ACLK) begin
        if (rst || soft_rst) begin
            int_pend <= 1'b0;
            overflow <= 1'b0;
            finish_d <= 1'b0;
        end else begin
            finish_d <= finish;
            // Rising edge of finish wins over a clear in the same cycle
            if (finish && !finish_d) begin
                int_pend <= 1'b1;
            end else if (int_wr && wdata[1]) begin
                int_pend <= 1'b0;
            end
            if (fifo_wr && fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (rden) begin
            case (rdaddr)
                `DRW_REG_STATUS: rdata <= {4'd0, fifo_count, 13'd0, overflow, finish, busy};
                `DRW_REG_INT:    rdata <= {30'd0, int_pend, int_en};
                `DRW_REG_ERRNO:  rdata <= {16'd0, errno};
                default:         rdata <= 32'd0;
            endcase
        end
    end

endmodule

// ==== hw/drw_cmd_fifo.sv ====
// Command FIFO with registered output, valid flag, occupancy count and clear
`timescale 1ns/10ps
`include "drw_cfg.svh"

module drw_cmd_fifo import drw_pkg::*; #(
    parameter int DEPTH = `DRW_FIFO_DEPTH
) (
    input  logic                   ACLK,
    input  logic                   rst,
    input  logic                   clr,
    input  logic                   wr,
    input  drw_cmd_word_u          din,
    input  logic                   rd,
    output drw_cmd_word_u          dout,
    output logic                   valid,
    output logic                   full,
    output logic                   empty,
    output logic [$clog2(DEPTH):0] count
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    drw_cmd_word_u mem [DEPTH];
    logic [AW-1:0] wp;
    logic [AW-1:0] rp;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wp] <= din;
        end
        if (do_rd) begin
            dout <= mem[rp];
        end
    end

    always_ff @(posedge ACLK) begin
        if (rst || clr) begin
            wp    <= '0;
            rp    <= '0;
            count <= '0;
            valid <= 1'b0;
        end else begin
            if (do_wr) begin
                wp <= wp + 1'b1;
            end
            if (do_rd) begin
                rp <= rp + 1'b1;
            end
            count <= count + CW'(do_wr) - CW'(do_rd);
            valid <= do_rd;
        end
    end

endmodule

// ==== hw/drw_cmd.sv ====
// Command decoder FSM with frame, colour and rectangle parameter registers
`timescale 1ns/10ps
`include "drw_cfg.svh"

module drw_cmd import drw_pkg::*; (
    input  logic          ACLK,
    input  logic          rst,
    input  logic          soft_rst,
    input  logic          exe,
    output logic          busy,
    output logic          finish,
    output drw_errno_e    errno,
    output logic          fifo_rd,
    input  drw_cmd_word_u fifo_dout,
    input  logic          fifo_valid,
    output logic          rect_start,
    output logic [28:0]   rect_addr,
    output logic [10:0]   rect_width,
    output logic [10:0]   rect_height,
    output logic [10:0]   frame_width,
    input  logic          rect_done,
    output logic [31:0]   fill_color
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_HDR   = 3'd1;
    localparam logic [2:0] S_ARG   = 3'd2;
    localparam logic [2:0] S_CHECK = 3'd3;
    localparam logic [2:0] S_START = 3'd4;
    localparam logic [2:0] S_WAIT  = 3'd5;
    localparam logic [2:0] S_END   = 3'd6;

    logic [2:0]  state;
    logic        rd_q;
    logic        arg_idx;
    drw_opcode_e op;
    logic [28:0] frame_base;
    logic [10:0] frame_height;
    logic [10:0] pos_x;
    logic [10:0] pos_y;
    logic [21:0] row_off;
    logic [11:0] right_edge;
    logic [11:0] bottom_edge;
    logic        bad_range;

    // One read in flight, next request once the word is back
    assign fifo_rd    = ((state == S_HDR) || (state == S_ARG)) && !rd_q;
    assign rect_start = (state == S_START);

    assign row_off     = pos_y * frame_width;
    assign right_edge  = {1'b0, pos_x} + {1'b0, rect_width};
    assign bottom_edge = {1'b0, pos_y} + {1'b0, rect_height};
    assign bad_range   = (rect_width == 11'd0) || (rect_height == 11'd0) ||
                         (right_edge > {1'b0, frame_width}) ||
                         (bottom_edge > {1'b0, frame_height});

    always_ff @(posedge ACLK) begin
        if (rst || soft_rst) begin
            state   <= S_IDLE;
            rd_q    <= 1'b0;
            arg_idx <= 1'b0;
            busy    <= 1'b0;
            finish  <= 1'b0;
            errno   <= ERR_NONE;
        end else begin
            rd_q <= fifo_rd;
            case (state)
                S_IDLE: if (exe) begin
                    busy   <= 1'b1;
                    finish <= 1'b0;
                    errno  <= ERR_NONE;
                    state  <= S_HDR;
                end
                S_HDR: if (fifo_valid) begin
                    arg_idx <= 1'b0;
                    case (fifo_dout.hdr.opcode)
                        OP_SETFRAME, OP_SETCOLOR, OP_FILLRECT: state <= S_ARG;
                        OP_END: state <= S_END;
                        default: begin
                            errno <= ERR_OPCODE;
                            state <= S_END;
                        end
                    endcase
                end
                S_ARG: if (fifo_valid) begin
                    arg_idx <= !arg_idx;
                    if (op == OP_SETCOLOR || arg_idx) begin
                        state <= (op == OP_FILLRECT) ? S_CHECK : S_HDR;
                    end
                end
                S_CHECK: begin
                    if (bad_range) begin
                        errno <= ERR_RANGE;
                        state <= S_END;
                    end else if (rect_width > 11'(`DRW_MAX_BURST)) begin
                        errno <= ERR_WIDTH;
                        state <= S_END;
                    end else begin
                        state <= S_START;
                    end
                end
                S_START: state <= S_WAIT;
                S_WAIT: if (rect_done) begin
                    state <= S_HDR;
                end
                S_END: begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                    state  <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Parameter capture
    always_ff @(posedge ACLK) begin
        if (state == S_HDR && fifo_valid) begin
            op <= drw_opcode_e'(fifo_dout.hdr.opcode);
        end
        if (state == S_ARG && fifo_valid) begin
            case (op)
                OP_SETFRAME: begin
                    if (!arg_idx) begin
                        frame_base <= fifo_dout.raw[28:0];
                    end else begin
                        frame_width  <= fifo_dout.pair.hi[10:0];
                        frame_height <= fifo_dout.pair.lo[10:0];
                    end
                end
                OP_SETCOLOR: fill_color <= fifo_dout.raw;
                default: begin
                    if (!arg_idx) begin
                        pos_x <= fifo_dout.pair.hi[10:0];
                        pos_y <= fifo_dout.pair.lo[10:0];
                    end else begin
                        rect_width  <= fifo_dout.pair.hi[10:0];
                        rect_height <= fifo_dout.pair.lo[10:0];
                    end
                end
            endcase
        end
        if (state == S_CHECK) begin
            rect_addr <= frame_base + {7'd0, row_off} + {18'd0, pos_x};
        end
    end

endmodule

// ==== hw/drw_mkaddr.sv ====
// Row walker turning a rectangle into one burst request per row
`timescale 1ns/10ps
`include "drw_cfg.svh"

module drw_mkaddr (
    input  logic        ACLK,
    input  logic        rst,
    input  logic        soft_rst,
    input  logic        rect_start,
    input  logic [28:0] rect_addr,
    input  logic [10:0] rect_width,
    input  logic [10:0] rect_height,
    input  logic [10:0] frame_width,
    output logic        rect_done,
    output logic        burst_req,
    output logic [31:0] burst_addr,
    output logic [7:0]  burst_len,
    input  logic        burst_ack
);

    logic        active;
    logic [28:0] row_addr;
    logic [10:0] rows_left;
    logic [10:0] stride;
    logic [10:0] len_m1;

    assign len_m1     = rect_width - 11'd1;
    assign burst_req  = active;
    // Word address to byte address inside the VRAM window
    assign burst_addr = {`DRW_VRAM_BASE, row_addr[26:0], 2'b00};

    always_ff @(posedge ACLK) begin
        if (rst || soft_rst) begin
            active    <= 1'b0;
            rect_done <= 1'b0;
        end else begin
            rect_done <= 1'b0;
            if (rect_start) begin
                active <= 1'b1;
            end else if (burst_ack && rows_left == 11'd1) begin
                active    <= 1'b0;
                rect_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (rect_start) begin
            row_addr  <= rect_addr;
            rows_left <= rect_height;
            stride    <= frame_width;
            burst_len <= len_m1[7:0];
        end else if (burst_ack) begin
            // Next row, one frame stride down
            row_addr  <= row_addr + {18'd0, stride};
            rows_left <= rows_left - 11'd1;
        end
    end

endmodule

// ==== hw/drw_vramctrl_wr.sv ====
// AXI4 write master filling one burst with the current colour
`timescale 1ns/10ps

module drw_vramctrl_wr (
    input  logic        ACLK,
    input  logic        rst,
    input  logic        soft_rst,
    input  logic        burst_req,
    input  logic [31:0] burst_addr,
    input  logic [7:0]  burst_len,
    input  logic [31:0] fill_color,
    output logic        burst_ack,
    output logic        awvalid,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic        wvalid,
    output logic [31:0] wdata_m,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        bready,
    input  logic        awready,
    input  logic        wready,
    input  logic        bvalid,
    input  logic [1:0]  bresp
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_RESP = 2'd3;

    logic [1:0] state;
    logic [7:0] beat;

    assign awvalid   = (state == S_ADDR);
    assign wvalid    = (state == S_DATA);
    assign bready    = (state == S_RESP);
    assign awsize    = 3'b010;
    assign wstrb     = 4'hF;
    assign wdata_m   = fill_color;
    assign wlast     = wvalid && (beat == awlen);
    // Response status not checked, any B ends the burst
    assign burst_ack = bready && bvalid;

    always_ff @(posedge ACLK) begin
        if (rst || soft_rst) begin
            state <= S_IDLE;
            beat  <= 8'd0;
        end else begin
            case (state)
                S_IDLE: if (burst_req) begin
                    state <= S_ADDR;
                end
                S_ADDR: if (awready) begin
                    beat  <= 8'd0;
                    state <= S_DATA;
                end
                S_DATA: if (wready) begin
                    if (wlast) begin
                        state <= S_RESP;
                    end else begin
                        beat <= beat + 8'd1;
                    end
                end
                default: if (bvalid) begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (state == S_IDLE && burst_req) begin
            awaddr <= burst_addr;
            awlen  <= burst_len;
        end
    end

endmodule

// ==== hw/draw_top.sv ====
// Drawing engine top level: register block, command FIFO, decoder, row walker, AXI writer
`timescale 1ns/10ps

module draw_top import drw_pkg::*; (
    input  logic        ACLK,
    input  logic        rst,
    // Register bus
    input  logic [15:0] wraddr,
    input  logic        wren,
    input  logic [31:0] wdata,
    input  logic [15:0] rdaddr,
    input  logic        rden,
    output logic [31:0] rdata,
    output logic        irq,
    // AXI4 write
    output logic        awvalid,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic        wvalid,
    output logic [31:0] wdata_m,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        bready,
    input  logic        awready,
    input  logic        wready,
    input  logic        bvalid,
    input  logic [1:0]  bresp
);

    logic          fifo_wr;
    drw_cmd_word_u fifo_din;
    logic          fifo_full;
    logic [11:0]   fifo_count;
    logic          fifo_rd;
    drw_cmd_word_u fifo_dout;
    logic          fifo_valid;

    logic          exe;
    logic          soft_rst;
    logic          busy;
    logic          finish;
    drw_errno_e    errno;

    logic          rect_start;
    logic [28:0]   rect_addr;
    logic [10:0]   rect_width;
    logic [10:0]   rect_height;
    logic [10:0]   frame_width;
    logic          rect_done;
    logic [31:0]   fill_color;

    logic          burst_req;
    logic [31:0]   burst_addr;
    logic [7:0]    burst_len;
    logic          burst_ack;

    drw_regctrl u_regctrl (
        .ACLK       (ACLK),
        .rst        (rst),
        .wraddr     (wraddr),
        .wren       (wren),
        .wdata      (wdata),
        .rdaddr     (rdaddr),
        .rden       (rden),
        .rdata      (rdata),
        .fifo_wr    (fifo_wr),
        .fifo_din   (fifo_din),
        .fifo_full  (fifo_full),
        .fifo_count (fifo_count),
        .exe        (exe),
        .soft_rst   (soft_rst),
        .irq        (irq),
        .busy       (busy),
        .finish     (finish),
        .errno      (errno)
    );

    drw_cmd_fifo u_cmd_fifo (
        .ACLK  (ACLK),
        .rst   (rst),
        .clr   (soft_rst),
        .wr    (fifo_wr),
        .din   (fifo_din),
        .rd    (fifo_rd),
        .dout  (fifo_dout),
        .valid (fifo_valid),
        .full  (fifo_full),
        .empty (),
        .count (fifo_count)
    );

    drw_cmd u_cmd (
        .ACLK        (ACLK),
        .rst         (rst),
        .soft_rst    (soft_rst),
        .exe         (exe),
        .busy        (busy),
        .finish      (finish),
        .errno       (errno),
        .fifo_rd     (fifo_rd),
        .fifo_dout   (fifo_dout),
        .fifo_valid  (fifo_valid),
        .rect_start  (rect_start),
        .rect_addr   (rect_addr),
        .rect_width  (rect_width),
        .rect_height (rect_height),
        .frame_width (frame_width),
        .rect_done   (rect_done),
        .fill_color  (fill_color)
    );

    drw_mkaddr u_mkaddr (
        .ACLK        (ACLK),
        .rst         (rst),
        .soft_rst    (soft_rst),
        .rect_start  (rect_start),
        .rect_addr   (rect_addr),
        .rect_width  (rect_width),
        .rect_height (rect_height),
        .frame_width (frame_width),
        .rect_done   (rect_done),
        .burst_req   (burst_req),
        .burst_addr  (burst_addr),
        .burst_len   (burst_len),
        .burst_ack   (burst_ack)
    );

    drw_vramctrl_wr u_vramctrl_wr (
        .ACLK       (ACLK),
        .rst        (rst),
        .soft_rst   (soft_rst),
        .burst_req  (burst_req),
        .burst_addr (burst_addr),
        .burst_len  (burst_len),
        .fill_color (fill_color),
        .burst_ack  (burst_ack),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .wvalid     (wvalid),
        .wdata_m    (wdata_m),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .bready     (bready),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp)
    );

endmodule

// ==== verification/draw_assert.sv ====
// Bound checks on AXI write channel stability, wlast, address window, reset values and irq gating
`timescale 1ns/10ps
`include "drw_cfg.svh"

module draw_assert (
    input logic        ACLK,
    input logic        rst,
    input logic [15:0] wraddr,
    input logic        wren,
    input logic [31:0] wdata,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic [7:0]  awlen,
    input logic [2:0]  awsize,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata_m,
    input logic        wlast,
    input logic        bready,
    input logic        irq
);

    int         fail_count = 0;
    logic [7:0] beats;
    logic       en_seen;

    // Beat number inside the current W burst
    always_ff @(posedge ACLK) begin
        if (rst) begin
            beats <= 8'd0;
        end else if (wvalid && wready) begin
            beats <= wlast ? 8'd0 : beats + 8'd1;
        end
    end

    // Interrupt enable as last written by the host
    always_ff @(posedge ACLK) begin
        if (rst) begin
            en_seen <= 1'b0;
        end else if (wren && (wraddr == `DRW_REG_INT)) begin
            en_seen <= wdata[0];
        end
    end

    aw_hold: assert property (@(posedge ACLK) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen) && $stable(awsize))
    else begin
        fail_count++;
        $error("AW channel changed while awready was low");
    end

    w_hold: assert property (@(posedge ACLK) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata_m) && $stable(wlast))
    else begin
        fail_count++;
        $error("W channel changed while wready was low");
    end

    last_beat: assert property (@(posedge ACLK) disable iff (rst)
        wvalid |-> (wlast == (beats == awlen)))
    else begin
        fail_count++;
        $error("wlast not on beat awlen+1");
    end

    vram_window: assert property (@(posedge ACLK) disable iff (rst)
        awvalid |-> (awaddr >= 32'h2000_0000) && (awaddr <= 32'h3FFF_FFFF))
    else begin
        fail_count++;
        $error("awaddr outside the VRAM window");
    end

    irq_gated: assert property (@(posedge ACLK) disable iff (rst) !en_seen |-> !irq)
    else begin
        fail_count++;
        $error("irq high with the interrupt disabled");
    end

    reset_idle: assert property (@(posedge ACLK)
        rst |=> !awvalid && !wvalid && !bready && !irq)
    else begin
        fail_count++;
        $error("outputs not idle after reset");
    end

endmodule

bind draw_top draw_assert chk0 (
    .ACLK    (ACLK),
    .rst     (rst),
    .wraddr  (wraddr),
    .wren    (wren),
    .wdata   (wdata),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awsize  (awsize),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata_m (wdata_m),
    .wlast   (wlast),
    .bready  (bready),
    .irq     (irq)
);

// ==== verification/tb_draw.sv ====
// Testbench for the drawing engine: clock, register bus tasks, AXI memory model, scenarios
`timescale 1ns/10ps
`include "drw_cfg.svh"

module tb_draw;

    localparam logic [28:0] BASE_A  = 29'h0010_0000;
    localparam logic [28:0] BASE_B  = 29'h0020_0000;
    localparam logic [31:0] COLOR_1 = 32'h00FF_8040;
    localparam logic [31:0] COLOR_2 = 32'h1234_ABCD;

    logic        ACLK = 1'b0;
    logic        rst;
    logic [15:0] wraddr;
    logic        wren;
    logic [31:0] wdata;
    logic [15:0] rdaddr;
    logic        rden;
    logic [31:0] rdata;
    logic        irq;
    logic        awvalid;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic        wvalid;
    logic [31:0] wdata_m;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        bready;
    logic        awready = 1'b0;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    logic [1:0]  bresp = 2'b00;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] model [logic [31:0]];
    logic [31:0] waddr;
    bit          b_pending;
    bit          stall;
    bit          seeded;
    int          mismatches;
    int          timeouts;

    draw_top dut0 (.*);

    always #10 ACLK = ~ACLK;

    // Memory side of the AXI write channels
    always @(posedge ACLK) begin
        if (awvalid && awready) begin
            waddr = awaddr;
            // Four-byte beats
            expect_eq("awsize", {29'd0, awsize}, 32'd2);
        end
        if (wvalid && wready) begin
            expect_eq("wstrb", {28'd0, wstrb}, 32'hF);
            mem[waddr] = wdata_m;
            waddr = waddr + 32'd4;
            if (wlast) begin
                b_pending = 1'b1;
            end
        end
        if (bvalid && bready) begin
            b_pending = 1'b0;
        end
    end

    // Ready and response lines, random holes only while stalling
    always @(negedge ACLK) begin
        if (!seeded) begin
            void'($urandom(32'h282f_0635));
            seeded = 1'b1;
        end
        awready <= !stall || ($urandom_range(3, 0) != 0);
        wready  <= !stall || ($urandom_range(3, 0) != 0);
        bvalid  <= b_pending && (bvalid || !stall || ($urandom_range(3, 0) != 0));
    end

    function automatic logic [31:0] hdr(input logic [7:0] op);
        return {op, 24'd0};
    endfunction

    function automatic logic [31:0] pair(input logic [15:0] hi, input logic [15:0] lo);
        return {hi, lo};
    endfunction

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        @(negedge ACLK);
        wraddr = addr;
        wdata  = data;
        wren   = 1'b1;
        @(negedge ACLK);
        wren = 1'b0;
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [31:0] data);
        @(negedge ACLK);
        rdaddr = addr;
        rden   = 1'b1;
        @(negedge ACLK);
        rden = 1'b0;
        data = rdata;
    endtask

    task automatic push_word(input logic [31:0] w);
        reg_write(`DRW_REG_FIFO, w);
    endtask

    task automatic set_frame(input logic [28:0] base, input logic [15:0] w,
                             input logic [15:0] h, input logic [31:0] color);
        push_word(hdr(`DRW_OP_SETFRAME));
        push_word({3'd0, base});
        push_word(pair(w, h));
        push_word(hdr(`DRW_OP_SETCOLOR));
        push_word(color);
    endtask

    task automatic fill_rect(input logic [15:0] x, input logic [15:0] y,
                             input logic [15:0] w, input logic [15:0] h);
        push_word(hdr(`DRW_OP_FILLRECT));
        push_word(pair(x, y));
        push_word(pair(w, h));
    endtask

    // 14 words, two overlapping rectangles
    task automatic load_fill_program();
        set_frame(BASE_A, 16'd64, 16'd48, COLOR_1);
        fill_rect(16'd3, 16'd5, 16'd10, 16'd4);
        push_word(hdr(`DRW_OP_SETCOLOR));
        push_word(COLOR_2);
        fill_rect(16'd10, 16'd7, 16'd8, 16'd3);
        push_word(hdr(`DRW_OP_END));
    endtask

    // Expected picture, byte address of pixel (x+c, y+r) in the window
    task automatic paint_model(input logic [28:0] base, input int fw, input int x, input int y,
                               input int w, input int h, input logic [31:0] color);
        logic [28:0] word;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                word = base + 29'((y + r) * fw + x + c);
                model[{3'b001, word[26:0], 2'b00}] = color;
            end
        end
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_memory();
        foreach (model[a]) begin
            assert (mem.exists(a) && mem[a] === model[a]) else begin
                mismatches++;
                $display("Mismatch at %0t ns: pixel %h expected %h actual %h", $time, a,
                         model[a], mem.exists(a) ? mem[a] : 32'hx);
            end
        end
        foreach (mem[a]) begin
            assert (model.exists(a)) else begin
                mismatches++;
                $display("Mismatch at %0t ns: pixel %h expected untouched actual %h",
                         $time, a, mem[a]);
            end
        end
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (!irq && n < 20000) begin
            @(negedge ACLK);
            n++;
        end
        if (!irq) begin
            timeouts++;
            $display("Timeout: the interrupt was never raised");
        end
    endtask

    task automatic wait_finish();
        logic [31:0] v;
        int n;
        v = 32'd0;
        n = 0;
        while (!v[1] && n < 2000) begin
            reg_read(`DRW_REG_STATUS, v);
            n++;
        end
        if (!v[1]) begin
            timeouts++;
            $display("Timeout: the finish bit was never set");
        end
    endtask

    // Run the queued commands, then check status, error number, irq and memory
    task automatic execute(input bit use_irq, input logic [15:0] exp_errno);
        logic [31:0] v;
        reg_write(`DRW_REG_CTRL, 32'h1);
        if (use_irq) begin
            wait_irq();
        end else begin
            wait_finish();
        end
        reg_read(`DRW_REG_STATUS, v);
        expect_eq("STATUS flags", v & 32'h7, 32'h2);
        reg_read(`DRW_REG_ERRNO, v);
        expect_eq("ERRNO", v, {16'd0, exp_errno});
        if (use_irq) begin
            reg_write(`DRW_REG_INT, 32'h3);
        end
        expect_eq("irq", {31'd0, irq}, 32'd0);
        // Drop words left behind by a failed program
        reg_write(`DRW_REG_CTRL, 32'h2);
        compare_memory();
    endtask

    initial begin
        logic [31:0] v;
        rst    = 1'b1;
        wraddr = 16'd0;
        wren   = 1'b0;
        wdata  = 32'd0;
        rdaddr = 16'd0;
        rden   = 1'b0;
        repeat (2) @(negedge ACLK);
        rst = 1'b0;

        reg_read(`DRW_REG_STATUS, v);
        expect_eq("STATUS after reset", v, 32'd0);
        expect_eq("irq after reset", {31'd0, irq}, 32'd0);
        reg_write(`DRW_REG_INT, 32'h1);
        load_fill_program();
        reg_read(`DRW_REG_STATUS, v);
        expect_eq("FIFO count", v, {4'd0, 12'd14, 16'd0});

        paint_model(BASE_A, 64, 3, 5, 10, 4, COLOR_1);
        paint_model(BASE_A, 64, 10, 7, 8, 3, COLOR_2);
        execute(1'b1, 16'd0);

        // Same picture under back-pressure
        stall = 1'b1;
        mem.delete();
        load_fill_program();
        execute(1'b1, 16'd0);

        mem.delete();
        model.delete();
        set_frame(BASE_A, 16'd64, 16'd48, COLOR_2);
        fill_rect(16'd1, 16'd1, 16'd2, 16'd2);
        fill_rect(16'd60, 16'd0, 16'd8, 16'd2);
        push_word(hdr(`DRW_OP_END));
        paint_model(BASE_A, 64, 1, 1, 2, 2, COLOR_2);
        execute(1'b1, `DRW_ERR_RANGE);

        set_frame(BASE_B, 16'd400, 16'd20, COLOR_1);
        fill_rect(16'd0, 16'd0, 16'd300, 16'd1);
        push_word(hdr(`DRW_OP_END));
        execute(1'b1, `DRW_ERR_WIDTH);

        // Interrupt off, end seen through the finish bit
        reg_write(`DRW_REG_INT, 32'h0);
        set_frame(BASE_B, 16'd32, 16'd32, COLOR_1);
        push_word(hdr(8'h7E));
        push_word(hdr(`DRW_OP_END));
        execute(1'b0, `DRW_ERR_OPCODE);

        for (int i = 0; i < 3; i++) begin
            push_word(hdr(`DRW_OP_END));
        end
        reg_read(`DRW_REG_STATUS, v);
        expect_eq("FIFO count", v, {4'd0, 12'd3, 16'd0});
        reg_write(`DRW_REG_CTRL, 32'h2);
        reg_read(`DRW_REG_STATUS, v);
        expect_eq("STATUS after soft reset", v, 32'd0);
        for (int i = 0; i < 2049; i++) begin
            push_word(hdr(`DRW_OP_END));
        end
        reg_read(`DRW_REG_STATUS, v);
        expect_eq("STATUS on overflow", v, {4'd0, 12'd2048, 16'h0004});
        reg_write(`DRW_REG_CTRL, 32'h2);
        reg_read(`DRW_REG_STATUS, v);
        expect_eq("STATUS after soft reset", v, 32'd0);

        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, dut0.chk0.fail_count);
        if (mismatches == 0 && timeouts == 0 && dut0.chk0.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== draw.f ====
+incdir+hw
hw/drw_pkg.sv
hw/drw_regctrl.sv
hw/drw_cmd_fifo.sv
hw/drw_cmd.sv
hw/drw_mkaddr.sv
hw/drw_vramctrl_wr.sv
hw/draw_top.sv
verification/draw_assert.sv
verification/tb_draw.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_draw with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f draw.f --top-module tb_draw
	./obj_dir/Vtb_draw +verilator+error+limit+1000 > sim.log 2>&1; rc=$$?; \
	cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "TEST FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
